// File: design/bnn_config.svh
`ifndef BNN_CONFIG_SVH
`define BNN_CONFIG_SVH

`define BNN_FEATURES    12
`define BNN_FEAT_BITS   4
`define BNN_HIDDEN      40
`define BNN_CLASSES     6
// Worst-case hidden sum is 12 * 15 = 180 in magnitude, so 9 bits with sign
`define BNN_ACC_BITS    9
`define BNN_SCORE_BITS  6
`define BNN_CLASS_BITS  3

`endif

// File: design/bnn_pkg.sv
`include "bnn_config.svh"

package bnn_pkg;

  typedef logic [`BNN_FEATURES-1:0][`BNN_FEAT_BITS-1:0] features_t;

  typedef struct packed {
    logic                     valid;
    logic                     last;
    logic [`BNN_FEAT_BITS-1:0] value;
  } feature_beat_t;

  typedef struct packed {
    logic                   valid;
    logic [`BNN_HIDDEN-1:0] bits; // Sign per neuron, 1 = sum >= 0
  } hidden_vec_t;

  typedef struct packed {
    logic                                           valid;
    logic [`BNN_CLASSES-1:0][`BNN_SCORE_BITS-1:0] score;
  } class_scores_t;

  typedef struct packed {
    logic                       valid;
    logic [`BNN_CLASS_BITS-1:0] class_idx;
  } class_result_t;

  typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_e;
  typedef enum logic {POP_IDLE, POP_RUN} pop_state_e;

  // Bit feature*40 + neuron, 1 = add, 0 = subtract
  localparam logic [`BNN_FEATURES*`BNN_HIDDEN-1:0] HIDDEN_WEIGHTS = {
    80'hd3a5_6c91_e2f4_0b87_5a1c, 80'h9e36_47b2_c08d_f15a_3e69,
    80'h27c4_b9e1_58a0_6d3f_92b7, 80'hf1e0_4a6d_3c95_b782_0e5d,
    80'h6b29_d7f3_81c4_5ea0_c736, 80'h48af_2e91_7d0c_b36a_f5d2
  };

  // Bit class*40 + hidden index, expected hidden bit
  localparam logic [`BNN_CLASSES*`BNN_HIDDEN-1:0] OUT_WEIGHTS = {
    80'hc59b_1e73_a26f_04d8_9b3e, 80'h3f82_d6a4_5c17_e09b_71a5,
    80'ha4d1_8e3c_f760_2b95_4c8e
  };

endpackage

// File: design/feature_sequencer.sv
`include "bnn_config.svh"
`timescale 1ns/1ns

module feature_sequencer
  import bnn_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  features_t     features,
  input  logic          slot_free,
  output logic          ready,
  output feature_beat_t beat
);

  localparam int IDX_BITS = $clog2(`BNN_FEATURES);
  localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(`BNN_FEATURES - 1);

  seq_state_e          state;
  logic [IDX_BITS-1:0] idx;
  features_t           feat_q;
  logic                accept;

  // Last beat still in flight to the hidden layer also blocks a new start
  assign ready  = (state == SEQ_IDLE) && !beat.valid && slot_free;
  assign accept = start && ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= features; // Sample fixed at acceptance
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= SEQ_IDLE;
      idx   <= '0;
      beat  <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          beat <= '0;
          if (accept) begin
            state <= SEQ_RUN;
            idx   <= '0;
          end
        end
        SEQ_RUN: begin
          beat.valid <= 1'b1;
          beat.last  <= (idx == LAST_IDX);
          beat.value <= feat_q[idx];
          if (idx == LAST_IDX) begin
            state <= SEQ_IDLE;
            idx   <= '0;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: design/hidden_layer.sv
`include "bnn_config.svh"
`timescale 1ns/1ns

module hidden_layer
  import bnn_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  feature_beat_t beat,
  output hidden_vec_t   hidden
);

  localparam int IDX_BITS = $clog2(`BNN_FEATURES);

  logic [IDX_BITS-1:0]             feat_idx;
  logic [`BNN_HIDDEN-1:0]          op_bits;
  logic [`BNN_HIDDEN-1:0]          sign_next;
  logic signed [`BNN_ACC_BITS-1:0] operand;

  assign op_bits = HIDDEN_WEIGHTS[feat_idx*`BNN_HIDDEN +: `BNN_HIDDEN];
  assign operand = $signed({{(`BNN_ACC_BITS-`BNN_FEAT_BITS){1'b0}}, beat.value});

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      feat_idx <= '0;
    end else if (beat.valid) begin
      feat_idx <= beat.last ? '0 : feat_idx + 1'b1;
    end
  end

  for (genvar n = 0; n < `BNN_HIDDEN; n++) begin : g_neuron
    logic signed [`BNN_ACC_BITS-1:0] acc;
    logic signed [`BNN_ACC_BITS-1:0] acc_next;

    assign acc_next     = op_bits[n] ? acc + operand : acc - operand;
    assign sign_next[n] = ~acc_next[`BNN_ACC_BITS-1]; // Sum >= 0

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        acc <= '0;
      end else if (beat.valid) begin
        acc <= beat.last ? '0 : acc_next; // Clear for the next sample
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hidden <= '0;
    end else begin
      hidden.valid <= beat.valid && beat.last;
      if (beat.valid && beat.last) begin
        hidden.bits <= sign_next;
      end
    end
  end

endmodule

// File: design/xnor_popcount_layer.sv
`include "bnn_config.svh"
`timescale 1ns/1ns

module xnor_popcount_layer
  import bnn_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  hidden_vec_t   hidden,
  output logic          slot_free,
  output class_scores_t scores
);

  localparam int CNT_BITS = $clog2(`BNN_HIDDEN);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`BNN_HIDDEN - 1);
  // Remaining bits <= feature count once this many are consumed
  localparam logic [CNT_BITS-1:0] FREE_AT  = CNT_BITS'(`BNN_HIDDEN - `BNN_FEATURES);

  pop_state_e             state;
  logic [CNT_BITS-1:0]    bit_cnt;
  logic [CNT_BITS-1:0]    cur_idx;
  logic [`BNN_HIDDEN-1:0] hid_q;
  logic                   cur_bit;
  logic [`BNN_CLASSES-1:0] match;

  // Bit 0 is taken straight from the incoming vector
  assign cur_idx = hidden.valid ? '0 : bit_cnt;
  assign cur_bit = hidden.valid ? hidden.bits[0] : hid_q[bit_cnt];

  for (genvar c = 0; c < `BNN_CLASSES; c++) begin : g_match
    assign match[c] = ~(OUT_WEIGHTS[c*`BNN_HIDDEN + cur_idx] ^ cur_bit);
  end

  assign slot_free = ((state == POP_IDLE) && !hidden.valid) ||
                     ((state == POP_RUN) && (bit_cnt >= FREE_AT));

  always_ff @(posedge clk) begin
    if (hidden.valid) begin
      hid_q <= hidden.bits;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= POP_IDLE;
      bit_cnt <= '0;
      scores  <= '0;
    end else begin
      scores.valid <= 1'b0;
      if (hidden.valid) begin
        state   <= POP_RUN;
        bit_cnt <= CNT_BITS'(1);
        for (int c = 0; c < `BNN_CLASSES; c++) begin
          scores.score[c] <= {{(`BNN_SCORE_BITS-1){1'b0}}, match[c]};
        end
      end else if (state == POP_RUN) begin
        for (int c = 0; c < `BNN_CLASSES; c++) begin
          scores.score[c] <= scores.score[c] + {{(`BNN_SCORE_BITS-1){1'b0}}, match[c]};
        end
        if (bit_cnt == LAST_BIT) begin
          state        <= POP_IDLE;
          bit_cnt      <= '0;
          scores.valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/argmax_select.sv
`include "bnn_config.svh"
`timescale 1ns/1ns

module argmax_select
  import bnn_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  class_scores_t scores,
  output class_result_t result
);

  logic [`BNN_CLASS_BITS-1:0] best_idx;
  logic [`BNN_SCORE_BITS-1:0] best_score;

  always_comb begin
    best_idx   = '0;
    best_score = scores.score[0];
    for (int c = 1; c < `BNN_CLASSES; c++) begin
      if (scores.score[c] > best_score) begin // Strict, lowest index keeps a tie
        best_idx   = c[`BNN_CLASS_BITS-1:0];
        best_score = scores.score[c];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result <= '0;
    end else begin
      result.valid <= scores.valid;
      if (scores.valid) begin
        result.class_idx <= best_idx;
      end
    end
  end

endmodule

// File: design/bnn_classifier_top.sv
`timescale 1ns/1ns

module bnn_classifier_top
  import bnn_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  features_t     features,
  output logic          ready,
  output class_result_t result
);

  feature_beat_t beat;
  hidden_vec_t   hidden;
  class_scores_t scores;
  logic          slot_free; // Entrance back-pressure from the popcount layer

  feature_sequencer u_feature_sequencer (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .features  (features),
    .slot_free (slot_free),
    .ready     (ready),
    .beat      (beat)
  );

  hidden_layer u_hidden_layer (
    .clk    (clk),
    .rst    (rst),
    .beat   (beat),
    .hidden (hidden)
  );

  xnor_popcount_layer u_xnor_popcount_layer (
    .clk       (clk),
    .rst       (rst),
    .hidden    (hidden),
    .slot_free (slot_free),
    .scores    (scores)
  );

  argmax_select u_argmax_select (
    .clk    (clk),
    .rst    (rst),
    .scores (scores),
    .result (result)
  );

endmodule

// File: verif/bnn_tb_model.svh
`ifndef BNN_TB_MODEL_SVH
`define BNN_TB_MODEL_SVH

// Sign of each hidden sum, XNOR match count per class, lowest index wins a tie
function automatic logic [`BNN_CLASS_BITS-1:0] predict_class(input features_t f);
  logic [`BNN_HIDDEN-1:0]     h;
  logic [`BNN_CLASS_BITS-1:0] best;
  int sum;
  int score;
  int best_score;
  int best_idx;
  for (int n = 0; n < `BNN_HIDDEN; n++) begin
    sum = 0;
    for (int i = 0; i < `BNN_FEATURES; i++) begin
      if (HIDDEN_WEIGHTS[i*`BNN_HIDDEN + n]) sum += int'(f[i]);
      else sum -= int'(f[i]);
    end
    h[n] = (sum >= 0);
  end
  best_score = -1;
  best_idx   = 0;
  for (int c = 0; c < `BNN_CLASSES; c++) begin
    score = 0;
    for (int j = 0; j < `BNN_HIDDEN; j++) begin
      if (OUT_WEIGHTS[c*`BNN_HIDDEN + j] == h[j]) score++;
    end
    if (score > best_score) begin
      best_score = score;
      best_idx   = c;
    end
  end
  best = best_idx[`BNN_CLASS_BITS-1:0];
  return best;
endfunction

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic compare_class(input class_result_t got, input class_result_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED time=%0t signal=result got valid=%0b class=%0d expected valid=%0b class=%0d",
             $time, got.valid, got.class_idx, exp.valid, exp.class_idx);
  end
endtask

task automatic compare_ready(input logic got, input logic exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED time=%0t signal=ready got=%0b expected=%0b", $time, got, exp);
  end
endtask

task automatic compare_latency(input int got, input int exp);
  if (got != exp) begin
    value_errors++;
    $display("CHECK FAILED time=%0t signal=latency got=%0d expected=%0d", $time, got, exp);
  end
endtask

`endif

// File: verif/bnn_tb.sv
`timescale 1ns/1ns
`include "bnn_config.svh"

module bnn_tb
  import bnn_pkg::*;
();

  localparam int LATENCY     = 54;
  localparam int READY_LIMIT = 200;
  localparam int DRAIN_LIMIT = 400;

  logic          clk;
  logic          rst;
  logic          start;
  features_t     features;
  logic          ready;
  class_result_t result;

  int            cyc = 0;
  int            value_errors = 0;
  int            other_errors = 0;
  int            accepted = 0;
  int            results_seen = 0;
  int            max_in_flight = 0;
  bit            timed_out = 1'b0;
  logic [31:0]   lfsr_state;
  class_result_t exp_q[$];
  int            accept_cyc_q[$];
  features_t     f_a;
  features_t     f_b;

  `include "bnn_tb_model.svh"

  bnn_classifier_top u_bnn_classifier_top (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .features (features),
    .ready    (ready),
    .result   (result)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  always @(negedge clk) begin : check_results
    class_result_t exp_res;
    int            acc_cyc;
    if (result.valid === 1'b1) begin
      results_seen++;
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("ERROR at %0t: result valid with no accepted start pending", $time);
      end else begin
        exp_res = exp_q.pop_front();
        acc_cyc = accept_cyc_q.pop_front();
        compare_class(result, exp_res);
        compare_latency(cyc - acc_cyc, LATENCY);
      end
    end
  end

  task automatic random_features(output features_t f);
    logic [`BNN_FEATURES*`BNN_FEAT_BITS-1:0] raw;
    for (int b = 0; b < `BNN_FEATURES*`BNN_FEAT_BITS; b++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      raw[b]     = lfsr_state[0];
    end
    f = raw;
  endtask

  // Start seen with ready high at the negedge is taken at the next edge
  task automatic record_accept(input features_t f);
    class_result_t exp;
    exp.valid     = 1'b1;
    exp.class_idx = predict_class(f);
    exp_q.push_back(exp);
    accept_cyc_q.push_back(cyc + 1);
    accepted++;
    if (exp_q.size() > max_in_flight) max_in_flight = exp_q.size();
  endtask

  task automatic start_sample(input features_t f);
    int        waited;
    bit        taken;
    features_t junk;
    waited = 0;
    taken  = 1'b0;
    if (!timed_out) begin
      @(posedge clk);
      #1;
      start    = 1'b1;
      features = f;
      while (!taken && waited < READY_LIMIT) begin
        @(negedge clk);
        if (ready) begin
          taken = 1'b1;
          record_accept(f);
        end else begin
          waited++;
        end
      end
      @(posedge clk);
      #1;
      start = 1'b0;
      random_features(junk); // Scramble inputs right after acceptance
      features = junk;
      if (taken) begin
        @(negedge clk);
        compare_ready(ready, 1'b0);
      end else begin
        timed_out = 1'b1;
        other_errors++;
        $display("ERROR at %0t: ready stayed low for %0d cycles", $time, READY_LIMIT);
      end
    end
  endtask

  task automatic pulse_while_busy(input features_t f, input int gap);
    if (!timed_out) begin
      repeat (gap) @(posedge clk);
      @(posedge clk);
      #1;
      start    = 1'b1;
      features = f;
      @(negedge clk);
      compare_ready(ready, 1'b0);
      if (ready) record_accept(f);
      @(posedge clk);
      #1;
      start = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    if (!timed_out) begin
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (exp_q.size() != 0) begin
        timed_out = 1'b1;
        other_errors++;
        $display("ERROR at %0t: %0d results still missing after %0d cycles",
                 $time, exp_q.size(), DRAIN_LIMIT);
      end
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    features   = '0;
    lfsr_state = 32'h7b77efc7;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (20) begin // Idle after reset
      @(negedge clk);
      compare_ready(ready, 1'b1);
    end

    start_sample('0);
    wait_drain();
    start_sample('1); // Every feature at 15
    wait_drain();

    repeat (30) begin
      random_features(f_a);
      start_sample(f_a);
    end
    wait_drain();

    max_in_flight = 0;
    random_features(f_a);
    random_features(f_b);
    start_sample(f_a);
    start_sample(f_b);
    wait_drain();
    if (!timed_out && max_in_flight < 2) begin
      other_errors++;
      $display("ERROR: back-to-back samples were never in flight together");
    end

    random_features(f_a);
    start_sample(f_a);
    random_features(f_b);
    pulse_while_busy(f_b, 0); // Sequencer still streaming
    random_features(f_b);
    pulse_while_busy(f_b, 9); // Last beat in flight
    random_features(f_b);
    pulse_while_busy(f_b, 14); // Popcount layer busy
    random_features(f_a);
    start_sample(f_a);
    wait_drain();

    repeat (60) @(negedge clk); // Catch any extra result
    if (results_seen != accepted) begin
      other_errors++;
      $display("ERROR: %0d results seen for %0d accepted starts", results_seen, accepted);
    end
    end_run();
  end

endmodule

// File: compile.f
+incdir+design
+incdir+verif
design/bnn_pkg.sv
design/feature_sequencer.sv
design/hidden_layer.sv
design/xnor_popcount_layer.sv
design/argmax_select.sv
design/bnn_classifier_top.sv
verif/bnn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BNN classifier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module bnn_tb \
  -f compile.f --Mdir obj_dir -o bnn_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/bnn_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
